// ==== common/rf_cfg.svh ====
// ########################################
// Register execute core configuration
// Widths, queue depth and credit counts
// ########################################
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// Register width and register address width
`define RF_DATA_WIDTH 32
`define RF_ADDR_WIDTH 5

// Instruction queue entries, also the upstream credits after reset
`define RF_IN_DEPTH 4
// Result credits held by the execute unit after reset
`define RF_OUT_CREDITS 2

`endif

// ==== common/rfPkg.sv ====
// ########################################
// Register execute core types
// Opcode, instruction and result formats
// ########################################
`include "rf_cfg.svh"

package rfPkg;

	// Register value and register index
	typedef logic [`RF_DATA_WIDTH-1:0] data_t;
	typedef logic [`RF_ADDR_WIDTH-1:0] addr_t;

	// ALU operations
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,   // signed compare, 1 or 0
		OP_ADDI = 3'd6,   // rs1 + sign-extended imm
		OP_LUI  = 3'd7    // imm << 16
	} aluOp_e;

	// One queued instruction, 34 bits
	typedef struct packed {
		aluOp_e      op;
		addr_t       rd;
		addr_t       rs1;
		addr_t       rs2;
		logic [15:0] imm;
	} instr_t;

	// One result to downstream, 37 bits
	typedef struct packed {
		addr_t rd;
		data_t value;
	} result_t;

endpackage

// ==== common/regFileIf.sv ====
// ########################################
// Register file port bundle
// Two read ports and one write port
// ########################################
`timescale 1ns/1ps
`include "rf_cfg.svh"

interface regFileIf;

	// Read port 0
	rfPkg::addr_t addrRead0;
	logic         enRead0;
	rfPkg::data_t dataRead0;

	// Read port 1
	rfPkg::addr_t addrRead1;
	logic         enRead1;
	rfPkg::data_t dataRead1;

	// Write port
	rfPkg::addr_t addrWrite;
	rfPkg::data_t dataWrite;
	logic         enWrite;

	// Execute side
	modport client (
		output addrRead0, addrRead1, enRead0, enRead1,
		output addrWrite, dataWrite, enWrite,
		input  dataRead0, dataRead1
	);

	// Register file side
	modport regs (
		input  addrRead0, addrRead1, enRead0, enRead1,
		input  addrWrite, dataWrite, enWrite,
		output dataRead0, dataRead1
	);

endinterface

// ==== regfile/dualPortRam.sv ====
// ########################################
// Simple dual-port RAM
// Port A reads, port B writes, one clock
// ########################################
`timescale 1ns/1ps

module dualPortRam #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 5
) (
	input  logic                  iClk,
	// Read port
	input  logic [ADDR_WIDTH-1:0] addrA,
	input  logic                  enA,
	output logic [DATA_WIDTH-1:0] dataA,
	// Write port
	input  logic [ADDR_WIDTH-1:0] addrB,
	input  logic [DATA_WIDTH-1:0] dataB,
	input  logic                  weB
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	// Storage array
	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// Registered read
	// Same-address collision returns the old word
	always_ff @(posedge iClk) begin
		if (enA) begin
			dataA <= mem[addrA];
		end
	end

	// Write on the edge while enabled
	always_ff @(posedge iClk) begin
		if (weB) begin
			mem[addrB] <= dataB;
		end
	end

endmodule

// ==== regfile/regFile.sv ====
// ########################################
// Register file, two reads and one write
// Two RAM copies, r0 forced to zero and
// same-cycle write bypass
// ########################################
`timescale 1ns/1ps
`include "rf_cfg.svh"

module regFile (
	input  logic iClk,
	input  logic rst,
	regFileIf.regs rf
);

	// RAM read data, one copy per read port
	rfPkg::data_t ramData0;
	rfPkg::data_t ramData1;

	// Read addresses as seen by the RAMs
	rfPkg::addr_t addrRead0Q;
	rfPkg::addr_t addrRead1Q;

	// Write from the previous cycle
	rfPkg::addr_t addrWriteQ;
	rfPkg::data_t dataWriteQ;
	logic         enWriteQ;

	// Copy 0 serves read port 0
	dualPortRam #(
		.DATA_WIDTH(`RF_DATA_WIDTH),
		.ADDR_WIDTH(`RF_ADDR_WIDTH)
	) u_ram0 (
		.iClk (iClk),
		.addrA(rf.addrRead0),
		.enA  (rf.enRead0),
		.dataA(ramData0),
		.addrB(rf.addrWrite),
		.dataB(rf.dataWrite),
		.weB  (rf.enWrite)
	);

	// Copy 1 serves read port 1, same writes
	dualPortRam #(
		.DATA_WIDTH(`RF_DATA_WIDTH),
		.ADDR_WIDTH(`RF_ADDR_WIDTH)
	) u_ram1 (
		.iClk (iClk),
		.addrA(rf.addrRead1),
		.enA  (rf.enRead1),
		.dataA(ramData1),
		.addrB(rf.addrWrite),
		.dataB(rf.dataWrite),
		.weB  (rf.enWrite)
	);

	// Track addresses alongside the RAM output registers
	always_ff @(posedge iClk) begin
		if (rf.enRead0) begin
			addrRead0Q <= rf.addrRead0;
		end
		if (rf.enRead1) begin
			addrRead1Q <= rf.addrRead1;
		end
		addrWriteQ <= rf.addrWrite;
		dataWriteQ <= rf.dataWrite;
	end

	// Write valid flag
	always_ff @(posedge iClk) begin
		if (rst) begin
			enWriteQ <= 1'b0;
		end else begin
			enWriteQ <= rf.enWrite;
		end
	end

	// r0 first, then bypass of the collided write, else RAM
	assign rf.dataRead0 = (addrRead0Q == '0) ? '0 :
		(enWriteQ && addrRead0Q == addrWriteQ) ? dataWriteQ : ramData0;
	assign rf.dataRead1 = (addrRead1Q == '0) ? '0 :
		(enWriteQ && addrRead1Q == addrWriteQ) ? dataWriteQ : ramData1;

endmodule

// ==== hdl/instrQueue.sv ====
// ########################################
// Instruction queue with credit return
// Fall-through FIFO, one credit per pop
// ########################################
`timescale 1ns/1ps
`include "rf_cfg.svh"

module instrQueue (
	input  logic          iClk,
	input  logic          rst,
	// Push side, guarded by upstream credits
	input  logic          pushValid,
	input  rfPkg::instr_t pushData,
	// Pop side
	input  logic          pop,
	output logic          popValid,
	output rfPkg::instr_t popData,
	// One pulse per freed slot
	output logic          credit
);

	localparam int DEPTH = `RF_IN_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	rfPkg::instr_t mem [DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic             doPop;

	// Pop only counts when an entry is there
	assign doPop    = pop && popValid;
	assign popValid = (count != '0);
	assign popData  = mem[rdPtr];

	// Entry storage
	always_ff @(posedge iClk) begin
		if (pushValid) begin
			mem[wrPtr] <= pushData;
		end
	end

	// Pointers and fill level
	always_ff @(posedge iClk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			// Push never finds the queue full
			if (pushValid) begin
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			if (pushValid && !doPop) begin
				count <= count + 1'b1;
			end else if (doPop && !pushValid) begin
				count <= count - 1'b1;
			end
		end
	end

	// Credit follows the freed slot by one cycle
	always_ff @(posedge iClk) begin
		if (rst) begin
			credit <= 1'b0;
		end else begin
			credit <= doPop;
		end
	end

endmodule

// ==== hdl/execUnit.sv ====
// ########################################
// Issue and execute stages
// Register read, ALU, writeback and
// credited result output
// ########################################
`timescale 1ns/1ps
`include "rf_cfg.svh"

module execUnit (
	input  logic           iClk,
	input  logic           rst,
	// Instruction queue
	input  logic           popValid,
	input  rfPkg::instr_t  popData,
	output logic           pop,
	// Result link
	input  logic           resCredit,
	output logic           resValid,
	output rfPkg::result_t resData,
	// Register file
	regFileIf.client       rf
);

	localparam int CREDIT_W = $clog2(`RF_OUT_CREDITS + 1);

	logic [CREDIT_W-1:0] creditCnt;
	logic                issue;

	// Execute stage state
	logic                exValid;
	rfPkg::instr_t       exInstr;
	rfPkg::data_t        immExt;
	rfPkg::data_t        aluResult;

	// Issue needs an entry and a free result credit
	assign issue = popValid && (creditCnt != '0);
	assign pop   = issue;

	// Source reads start in the issue cycle
	assign rf.addrRead0 = popData.rs1;
	assign rf.addrRead1 = popData.rs2;
	assign rf.enRead0   = issue;
	assign rf.enRead1   = issue;

	// Credit taken at issue, returned by downstream
	always_ff @(posedge iClk) begin
		if (rst) begin
			creditCnt <= CREDIT_W'(`RF_OUT_CREDITS);
		end else begin
			case ({issue, resCredit})
				2'b10:   creditCnt <= creditCnt - 1'b1;
				2'b01:   creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	// Issue to execute handoff
	always_ff @(posedge iClk) begin
		if (rst) begin
			exValid <= 1'b0;
		end else begin
			exValid <= issue;
		end
	end

	always_ff @(posedge iClk) begin
		if (issue) begin
			exInstr <= popData;
		end
	end

	// Sign-extended immediate
	assign immExt = {{(`RF_DATA_WIDTH - 16){exInstr.imm[15]}}, exInstr.imm};

	// ALU on read data valid this cycle
	always_comb begin
		aluResult = '0;
		case (exInstr.op)
			rfPkg::OP_ADD:  aluResult = rf.dataRead0 + rf.dataRead1;
			rfPkg::OP_SUB:  aluResult = rf.dataRead0 - rf.dataRead1;
			rfPkg::OP_AND:  aluResult = rf.dataRead0 & rf.dataRead1;
			rfPkg::OP_OR:   aluResult = rf.dataRead0 | rf.dataRead1;
			rfPkg::OP_XOR:  aluResult = rf.dataRead0 ^ rf.dataRead1;
			rfPkg::OP_SLT: begin
				// Signed compare, zero-filled flag
				aluResult = {{(`RF_DATA_WIDTH - 1){1'b0}},
					($signed(rf.dataRead0) < $signed(rf.dataRead1))};
			end
			rfPkg::OP_ADDI: aluResult = rf.dataRead0 + immExt;
			rfPkg::OP_LUI:  aluResult = immExt << 16;
			default:        aluResult = '0;
		endcase
	end

	// Writeback in the execute cycle
	assign rf.addrWrite = exInstr.rd;
	assign rf.dataWrite = aluResult;
	assign rf.enWrite   = exValid;

	// Result output one cycle later
	always_ff @(posedge iClk) begin
		if (rst) begin
			resValid <= 1'b0;
		end else begin
			resValid <= exValid;
		end
	end

	always_ff @(posedge iClk) begin
		if (exValid) begin
			resData.rd    <= exInstr.rd;
			resData.value <= aluResult;
		end
	end

endmodule

// ==== hdl/regExecTop.sv ====
// ########################################
// Register execute core top level
// Queue, execute unit and register file
// ########################################
`timescale 1ns/1ps
`include "rf_cfg.svh"

module regExecTop (
	input  logic                      iClk,
	input  logic                      rst,
	// Instruction input, credit based
	input  logic                      instrValid,
	input  rfPkg::aluOp_e             instrOp,
	input  logic [`RF_ADDR_WIDTH-1:0] instrRd,
	input  logic [`RF_ADDR_WIDTH-1:0] instrRs1,
	input  logic [`RF_ADDR_WIDTH-1:0] instrRs2,
	input  logic [15:0]               instrImm,
	output logic                      inCredit,
	// Result output, credit based
	output logic                      resValid,
	output logic [`RF_ADDR_WIDTH-1:0] resRd,
	output logic [`RF_DATA_WIDTH-1:0] resValue,
	input  logic                      resCredit
);

	rfPkg::instr_t  inInstr;
	rfPkg::instr_t  qData;
	rfPkg::result_t result;
	logic           qValid;
	logic           qPop;

	// Pack the instruction fields
	assign inInstr.op  = instrOp;
	assign inInstr.rd  = instrRd;
	assign inInstr.rs1 = instrRs1;
	assign inInstr.rs2 = instrRs2;
	assign inInstr.imm = instrImm;

	// Unpack the result
	assign resRd    = result.rd;
	assign resValue = result.value;

	// Execute to register file bundle
	regFileIf u_rfIf ();

	instrQueue u_queue (
		.iClk     (iClk),
		.rst      (rst),
		.pushValid(instrValid),
		.pushData (inInstr),
		.pop      (qPop),
		.popValid (qValid),
		.popData  (qData),
		.credit   (inCredit)
	);

	execUnit u_exec (
		.iClk     (iClk),
		.rst      (rst),
		.popValid (qValid),
		.popData  (qData),
		.pop      (qPop),
		.resCredit(resCredit),
		.resValid (resValid),
		.resData  (result),
		.rf       (u_rfIf.client)
	);

	regFile u_regFile (
		.iClk(iClk),
		.rst (rst),
		.rf  (u_rfIf.regs)
	);

endmodule

// ==== tb/regExecTb.sv ====
// ########################################
// Register execute core testbench
// Random instructions against a register
// model, credits on both links
// ########################################
`timescale 1ns/1ps
`include "rf_cfg.svh"

module regExecTb;

	// Instruction count of all tests
	localparam int TOTAL_INSTR = 32 + 64 + 400 + 60 + 20;
	localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR + 1000;

	logic                      iClk;
	logic                      rst;
	logic                      instrValid;
	rfPkg::aluOp_e             instrOp;
	logic [`RF_ADDR_WIDTH-1:0] instrRd;
	logic [`RF_ADDR_WIDTH-1:0] instrRs1;
	logic [`RF_ADDR_WIDTH-1:0] instrRs2;
	logic [15:0]               instrImm;
	logic                      inCredit;
	logic                      resValid;
	logic [`RF_ADDR_WIDTH-1:0] resRd;
	logic [`RF_DATA_WIDTH-1:0] resValue;
	logic                      resCredit;

	// Register model and expected results in send order
	rfPkg::data_t   regModel [32];
	rfPkg::result_t expQ [$];
	rfPkg::result_t expRes;
	// Cycle numbers at which credits go back downstream
	int             dueQ [$];

	integer seed = 32'he630ebc5;
	int     cycleCnt = 0;
	int     upCredits = `RF_IN_DEPTH;
	int     sentTotal = 0;
	int     inCreditTotal = 0;
	int     resCount = 0;
	int     errCount = 0;
	int     testsFailed = 0;
	int     maxDelay = 5;
	logic   hold = 1'b0;

	regExecTop u_dut (
		.iClk      (iClk),
		.rst       (rst),
		.instrValid(instrValid),
		.instrOp   (instrOp),
		.instrRd   (instrRd),
		.instrRs1  (instrRs1),
		.instrRs2  (instrRs2),
		.instrImm  (instrImm),
		.inCredit  (inCredit),
		.resValid  (resValid),
		.resRd     (resRd),
		.resValue  (resValue),
		.resCredit (resCredit)
	);

	// 8 ns clock
	initial begin
		iClk = 1'b0;
		forever #4 iClk = ~iClk;
	end

	// Cycle count and run limit
	always @(posedge iClk) begin
		cycleCnt++;
		if (cycleCnt >= CYCLE_LIMIT) begin
			$display("Timeout: results still missing after %0d cycles", cycleCnt);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ALU rules of the instruction set
	function automatic rfPkg::data_t expectAlu(input rfPkg::aluOp_e op,
			input rfPkg::data_t a, input rfPkg::data_t b, input logic [15:0] imm);
		case (op)
			rfPkg::OP_ADD:  return a + b;
			rfPkg::OP_SUB:  return a - b;
			rfPkg::OP_AND:  return a & b;
			rfPkg::OP_OR:   return a | b;
			rfPkg::OP_XOR:  return a ^ b;
			rfPkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rfPkg::OP_ADDI: return a + {{16{imm[15]}}, imm};
			default:        return {imm, 16'h0000};
		endcase
	endfunction

	// Upstream side, called 1 ns after a rising edge
	task automatic sendInstr(input rfPkg::aluOp_e op, input int rd, input int rs1,
			input int rs2, input logic [15:0] imm);
		rfPkg::result_t res;
		// Stall until a queue slot is credited
		while (upCredits == 0) begin
			@(posedge iClk);
			#1;
		end
		instrOp    = op;
		instrRd    = rd[4:0];
		instrRs1   = rs1[4:0];
		instrRs2   = rs2[4:0];
		instrImm   = imm;
		instrValid = 1'b1;
		upCredits--;
		sentTotal++;
		// Model update in send order
		res.rd    = rd[4:0];
		res.value = expectAlu(op, regModel[rs1], regModel[rs2], imm);
		expQ.push_back(res);
		if (rd != 0) begin
			regModel[rd] = res.value;
		end
		@(posedge iClk);
		#1;
		instrValid = 1'b0;
	endtask

	// Wait for every result and every returned credit
	task automatic drainAll();
		while (expQ.size() != 0 || dueQ.size() != 0) begin
			@(posedge iClk);
		end
		repeat (4) @(posedge iClk);
		#1;
	endtask

	task automatic reportTest(input string name, input int errStart);
		if (errCount == errStart) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, errCount - errStart);
			testsFailed++;
		end
	endtask

	// Result and credit monitor, sampled mid-cycle
	always @(negedge iClk) begin
		if (!rst) begin
			if (inCredit) begin
				upCredits++;
				inCreditTotal++;
				assert (inCreditTotal <= sentTotal) else begin
					$display("More input credits returned than instructions sent");
					errCount++;
				end
			end
			if (resValid) begin
				resCount++;
				assert (expQ.size() > 0) else begin
					$display("Result arrived with no instruction outstanding");
					errCount++;
				end
				if (expQ.size() > 0) begin
					expRes = expQ.pop_front();
					assert (resRd === expRes.rd && resValue === expRes.value) else begin
						$display("FAIL %0t: result r%0d=%h, expected r%0d=%h", $time,
							resRd, resValue, expRes.rd, expRes.value);
						errCount++;
					end
				end
				// Credit back after 0 to maxDelay cycles
				dueQ.push_back(cycleCnt + ($unsigned($random(seed)) % (maxDelay + 1)));
			end
		end
	end

	// Downstream credit return, one pulse per cycle at most
	always @(posedge iClk) begin
		#1;
		if (!rst && !hold && dueQ.size() > 0 && dueQ[0] <= cycleCnt) begin
			resCredit = 1'b1;
			void'(dueQ.pop_front());
		end else begin
			resCredit = 1'b0;
		end
	end

	initial begin
		int errStart;
		int prevRd;
		int windowStart;
		int startCount;
		logic [31:0] r;
		rst        = 1'b1;
		instrValid = 1'b0;
		instrOp    = rfPkg::OP_ADD;
		instrRd    = '0;
		instrRs1   = '0;
		instrRs2   = '0;
		instrImm   = '0;
		resCredit  = 1'b0;
		// Unknown until written, r0 fixed
		for (int i = 0; i < 32; i++) begin
			regModel[i] = 'x;
		end
		regModel[0] = '0;
		repeat (10) @(posedge iClk);
		#1;
		rst = 1'b0;
		@(posedge iClk);
		#1;

		// Test 1: LUI to every register, then read them on both ports
		errStart = errCount;
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			sendInstr(rfPkg::OP_LUI, i, 0, 0, r[15:0]);
		end
		for (int i = 0; i < 32; i++) begin
			sendInstr(rfPkg::OP_ADD, i, i, 0, 16'h0);
			sendInstr(rfPkg::OP_OR, i, 0, i, 16'h0);
		end
		drainAll();
		reportTest("1 init", errStart);

		// Test 2: random mix of all opcodes
		errStart = errCount;
		for (int i = 0; i < 400; i++) begin
			r = $random(seed);
			sendInstr(rfPkg::aluOp_e'(r[2:0]), r[7:3], r[12:8], r[17:13], r[31:16]);
		end
		drainAll();
		reportTest("2 alu mix", errStart);

		// Test 3: dependency chains, credits back at once
		errStart = errCount;
		maxDelay = 0;
		for (int c = 0; c < 6; c++) begin
			r = $random(seed);
			prevRd = r[4:0];
			for (int i = 0; i < 10; i++) begin
				r = $random(seed);
				// Any op that reads rs1, nonzero rd keeps the chain live
				sendInstr(rfPkg::aluOp_e'($unsigned(r) % 7), 1 + (r[15:8] % 31), prevRd,
					r[20:16], r[31:16]);
				prevRd = 1 + (r[15:8] % 31);
			end
		end
		drainAll();
		reportTest("3 bypass", errStart);

		// Test 4: downstream withholds credits for 50 cycles
		errStart = errCount;
		maxDelay = 5;
		startCount = resCount;
		windowStart = resCount;
		hold = 1'b1;
		fork
			begin
				for (int i = 0; i < 20; i++) begin
					r = $random(seed);
					sendInstr(rfPkg::aluOp_e'(r[2:0]), r[7:3], r[12:8], r[17:13], r[31:16]);
				end
			end
			begin
				repeat (50) @(posedge iClk);
				assert (resCount - windowStart <= `RF_OUT_CREDITS) else begin
					$display("FAIL %0t: %0d results while credits withheld", $time,
						resCount - windowStart);
					errCount++;
				end
				hold = 1'b0;
			end
		join
		drainAll();
		assert (resCount - startCount == 20) else begin
			$display("Results lost under back-pressure, %0d of 20 arrived",
				resCount - startCount);
			errCount++;
		end
		reportTest("4 back-pressure", errStart);

		// Test 5: input credit balance
		errStart = errCount;
		assert (upCredits == `RF_IN_DEPTH && inCreditTotal == sentTotal) else begin
			$display("FAIL %0t: upstream holds %0d credits, %0d returned for %0d sent",
				$time, upCredits, inCreditTotal, sentTotal);
			errCount++;
		end
		reportTest("5 input credits", errStart);

		$display("Tests run 5, failed %0d, errors %0d, results %0d", testsFailed, errCount,
			resCount);
		if (errCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== regExecTop.f ====
+incdir+common
common/rfPkg.sv
common/regFileIf.sv
regfile/dualPortRam.sv
regfile/regFile.sv
hdl/instrQueue.sv
hdl/execUnit.sv
hdl/regExecTop.sv
tb/regExecTb.sv

// ==== Bender.yml ====
package:
  name: reg_exec_core

export_include_dirs:
  - common

sources:
  - files:
      - common/rfPkg.sv
      - common/regFileIf.sv
      - regfile/dualPortRam.sv
      - regfile/regFile.sv
      - hdl/instrQueue.sv
      - hdl/execUnit.sv
      - hdl/regExecTop.sv
  - target: test
    files:
      - tb/regExecTb.sv
